// File: verilog/ip_tx_defines.svh
/*
 * IPv4 transmit framer constants
 * datapath widths and the fixed IPv4 header values shared by the
 * packages and the RTL blocks
 */

`ifndef IP_TX_DEFINES_SVH
`define IP_TX_DEFINES_SVH

// payload bus width in bits
`define IP_TX_DATA_W 64

// one enable per byte lane
`define IP_TX_KEEP_W 8

// IPv4 header length without options
`define IP_TX_HDR_BYTES 20

// version 4, IHL 5
`define IP_TX_VERSION_IHL 8'h45

`endif

// File: verilog/ip_hdr_pkg.sv
/*
 * Header field types for the IPv4 transmit framer
 * Ethernet addressing and the caller-supplied IPv4 fields
 */

`default_nettype none

package ip_hdr_pkg;

    typedef struct packed {
        logic [47:0] dest_mac;
        logic [47:0] src_mac;
        logic [15:0] eth_type;
    } eth_hdr_t;

    // version, IHL and checksum are generated on chip
    typedef struct packed {
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        logic [15:0] length;
        logic [15:0] identification;
        logic [2:0]  flags;
        logic [12:0] fragment_offset;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [31:0] source_ip;
        logic [31:0] dest_ip;
    } ipv4_fields_t;

    // complete header as presented on s_hdr
    typedef struct packed {
        eth_hdr_t     eth;
        ipv4_fields_t ip;
    } ip_tx_hdr_t;

endpackage

`default_nettype wire

// File: verilog/axis_beat_pkg.sv
/*
 * Stream beat type
 * one 64-bit beat of a byte stream, lane 0 in the low bits,
 * with byte enables, end of frame and an error flag
 */

`default_nettype none

`include "ip_tx_defines.svh"

package axis_beat_pkg;

    typedef struct packed {
        logic [`IP_TX_DATA_W-1:0] data;
        logic [`IP_TX_KEEP_W-1:0] keep;
        // final beat of the frame
        logic                     last;
        // frame is bad
        logic                     user;
    } axis_beat_t;

endpackage

`default_nettype wire

// File: verilog/skid_reg.sv
/*
 * Two-entry output register
 * output register with a temporary register behind it, full
 * throughput and a registered input ready, for any payload type
 */

`timescale 1ns/1ps
`default_nettype none

module skid_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst,
    input  T     in_data,
    input  logic in_valid,
    output logic in_ready,
    output T     out_data,
    output logic out_valid,
    input  logic out_ready
);

    T     temp_data;
    logic temp_valid;
    logic out_valid_next;
    logic temp_valid_next;
    logic ready_next;
    logic in_to_out;
    logic in_to_temp;
    logic temp_to_out;

    // stay ready while the temp entry cannot fill next cycle
    assign ready_next = out_ready || (!temp_valid && (!out_valid || !in_valid));

    always_comb begin
        out_valid_next  = out_valid;
        temp_valid_next = temp_valid;
        in_to_out       = 1'b0;
        in_to_temp      = 1'b0;
        temp_to_out     = 1'b0;
        if (in_ready) begin
            if (out_ready || !out_valid) begin
                out_valid_next = in_valid;
                in_to_out      = 1'b1;
            end else begin
                // output stalled, park the entry
                temp_valid_next = in_valid;
                in_to_temp      = 1'b1;
            end
        end else if (out_ready) begin
            out_valid_next  = temp_valid;
            temp_valid_next = 1'b0;
            temp_to_out     = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid  <= 1'b0;
            temp_valid <= 1'b0;
            in_ready   <= 1'b1;
        end else begin
            out_valid  <= out_valid_next;
            temp_valid <= temp_valid_next;
            in_ready   <= ready_next;
        end
    end

    always_ff @(posedge clk) begin
        if (in_to_out) begin
            out_data <= in_data;
        end else if (temp_to_out) begin
            out_data <= temp_data;
        end
        if (in_to_temp) begin
            temp_data <= in_data;
        end
    end

endmodule

`default_nettype wire

// File: verilog/ip_hdr_builder.sv
/*
 * IPv4 header builder
 * holds the IPv4 fields of the current frame, computes the header
 * checksum at capture and forms the two leading 64-bit header words
 * in network byte order
 */

`timescale 1ns/1ps
`default_nettype none

`include "ip_tx_defines.svh"

module ip_hdr_builder (
    input  logic                       clk,
    input  logic                       capture,
    input  ip_hdr_pkg::ipv4_fields_t   hdr,
    input  logic                       word_sel,
    output logic [`IP_TX_DATA_W-1:0]   hdr_word,
    output logic [31:0]                dest_ip
);

    ip_hdr_pkg::ipv4_fields_t fields;
    logic [19:0]              sum;
    logic [16:0]              fold1;
    logic [15:0]              fold2;
    logic [15:0]              csum;
    logic [`IP_TX_DATA_W-1:0] word0;
    logic [`IP_TX_DATA_W-1:0] word1;

    // first byte on the wire goes to lane 0
    function automatic logic [31:0] to_lanes(input logic [31:0] v);
        return {v[7:0], v[15:8], v[23:16], v[31:24]};
    endfunction

    // one's-complement sum with the checksum field taken as zero
    always_comb begin
        sum = {`IP_TX_VERSION_IHL, hdr.dscp, hdr.ecn}
            + hdr.length
            + hdr.identification
            + {hdr.flags, hdr.fragment_offset}
            + {hdr.ttl, hdr.protocol}
            + hdr.source_ip[31:16]
            + hdr.source_ip[15:0]
            + hdr.dest_ip[31:16]
            + hdr.dest_ip[15:0];
        fold1 = sum[15:0] + sum[19:16];
        // second fold cannot carry again
        fold2 = fold1[15:0] + fold1[16];
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            fields <= hdr;
            csum   <= ~fold2;
        end
    end

    assign word0 = {to_lanes({fields.identification, fields.flags, fields.fragment_offset}),
                    to_lanes({`IP_TX_VERSION_IHL, fields.dscp, fields.ecn, fields.length})};
    assign word1 = {to_lanes(fields.source_ip),
                    to_lanes({fields.ttl, fields.protocol, csum})};

    assign hdr_word = word_sel ? word1 : word0;

    // lane-ordered, taken straight from the input for the preload edge
    assign dest_ip = to_lanes(hdr.dest_ip);

endmodule

`default_nettype wire

// File: verilog/payload_realign.sv
/*
 * Payload realignment by four bytes
 * joins the saved upper half of the previous input beat with the
 * lower half of the current one; the first beat carries the
 * destination IP in the low lanes, and a flush beat follows an
 * input last beat that used its upper lanes
 */

`timescale 1ns/1ps
`default_nettype none

`include "ip_tx_defines.svh"

module payload_realign (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      preload,
    input  logic [31:0]               preload_word,
    input  axis_beat_pkg::axis_beat_t in_beat,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  logic                      advance,
    output axis_beat_pkg::axis_beat_t out_beat,
    output logic                      out_valid
);

    localparam int HALF_W = `IP_TX_DATA_W / 2;
    localparam int HALF_K = `IP_TX_KEEP_W / 2;

    logic [HALF_W-1:0] save_data;
    logic [HALF_K-1:0] save_keep;
    logic              save_user;
    logic              flush;
    logic              upper_used;

    assign upper_used = |in_beat.keep[`IP_TX_KEEP_W-1:HALF_K];

    always_comb begin
        out_beat.data[HALF_W-1:0] = save_data;
        out_beat.keep[HALF_K-1:0] = save_keep;
        if (flush) begin
            // leftover upper half of the final input beat
            out_beat.data[`IP_TX_DATA_W-1:HALF_W] = '0;
            out_beat.keep[`IP_TX_KEEP_W-1:HALF_K] = '0;
            out_beat.last = 1'b1;
            out_beat.user = save_user;
            out_valid     = 1'b1;
            in_ready      = 1'b0;
        end else begin
            out_beat.data[`IP_TX_DATA_W-1:HALF_W] = in_beat.data[HALF_W-1:0];
            out_beat.keep[`IP_TX_KEEP_W-1:HALF_K] = in_beat.keep[HALF_K-1:0];
            // ends here only if nothing spills into a flush beat
            out_beat.last = in_beat.last && !upper_used;
            out_beat.user = in_beat.user && !upper_used;
            out_valid     = in_valid;
            in_ready      = advance;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            flush <= 1'b0;
        end else if (preload) begin
            flush <= 1'b0;
        end else if (advance) begin
            flush <= !flush && in_beat.last && upper_used;
        end
    end

    always_ff @(posedge clk) begin
        if (preload) begin
            save_data <= preload_word;
            save_keep <= '1;
            save_user <= 1'b0;
        end else if (advance && !flush) begin
            save_data <= in_beat.data[`IP_TX_DATA_W-1:HALF_W];
            save_keep <= in_beat.keep[`IP_TX_KEEP_W-1:HALF_K];
            save_user <= in_beat.user;
        end
    end

endmodule

`default_nettype wire

// File: verilog/ip_tx_ctrl.sv
/*
 * Framer control
 * frame FSM (idle, two header words, payload), output byte counter
 * checked against the IP total length, early termination flag and
 * the busy status
 */

`timescale 1ns/1ps
`default_nettype none

`include "ip_tx_defines.svh"

module ip_tx_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      hdr_valid,
    output logic                      hdr_ready,
    output logic                      capture,
    output logic                      word_sel,
    input  logic [15:0]               ip_length,
    input  logic                      eth_buf_ready,
    output logic                      eth_buf_valid,
    input  axis_beat_pkg::axis_beat_t realign_beat,
    input  logic                      realign_valid,
    output logic                      advance,
    input  logic [`IP_TX_DATA_W-1:0]  hdr_word,
    input  logic                      pay_buf_ready,
    output logic                      pay_buf_valid,
    output axis_beat_pkg::axis_beat_t pay_buf_beat,
    output logic                      busy,
    output logic                      error_payload_early_termination
);

    // dest IP rides in the first payload beat, so two words carry 16 bytes
    localparam logic [15:0] HDR_WORD_BYTES = 16'(`IP_TX_HDR_BYTES - 4);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HDR0,
        ST_HDR1,
        ST_PAYLOAD
    } state_t;

    state_t      state;
    state_t      state_next;
    logic        go;
    logic [15:0] ip_length_q;
    logic [15:0] byte_cnt;
    logic [15:0] byte_cnt_sum;
    logic [15:0] byte_cnt_next;
    logic        short_frame;
    logic        busy_q;
    logic        error_q;

    function automatic logic [15:0] keep_bytes(input logic [`IP_TX_KEEP_W-1:0] keep);
        logic [15:0] n;
        n = '0;
        for (int i = 0; i < `IP_TX_KEEP_W; i++) begin
            n = n + keep[i];
        end
        return n;
    endfunction

    assign go = eth_buf_ready && pay_buf_ready;
    assign byte_cnt_sum = byte_cnt + keep_bytes(realign_beat.keep);

    always_comb begin
        state_next    = state;
        hdr_ready     = 1'b0;
        capture       = 1'b0;
        eth_buf_valid = 1'b0;
        word_sel      = 1'b0;
        advance       = 1'b0;
        pay_buf_valid = 1'b0;
        pay_buf_beat  = realign_beat;
        byte_cnt_next = byte_cnt;
        short_frame   = 1'b0;

        case (state)
            ST_IDLE: begin
                hdr_ready = go;
                if (hdr_valid && go) begin
                    capture       = 1'b1;
                    eth_buf_valid = 1'b1;
                    state_next    = ST_HDR0;
                end
            end
            ST_HDR0, ST_HDR1: begin
                word_sel          = (state == ST_HDR1);
                pay_buf_beat.data = hdr_word;
                pay_buf_beat.keep = '1;
                pay_buf_beat.last = 1'b0;
                pay_buf_beat.user = 1'b0;
                if (go) begin
                    pay_buf_valid = 1'b1;
                    if (state == ST_HDR1) begin
                        byte_cnt_next = HDR_WORD_BYTES;
                        state_next    = ST_PAYLOAD;
                    end else begin
                        state_next = ST_HDR1;
                    end
                end
            end
            ST_PAYLOAD: begin
                // frame ended before the stated length
                short_frame       = realign_beat.last && (byte_cnt_sum < ip_length_q);
                pay_buf_beat.user = realign_beat.user || short_frame;
                if (go && realign_valid) begin
                    advance       = 1'b1;
                    pay_buf_valid = 1'b1;
                    byte_cnt_next = byte_cnt_sum;
                    if (realign_beat.last) begin
                        state_next = ST_IDLE;
                    end
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_IDLE;
            byte_cnt <= '0;
            busy_q   <= 1'b0;
            error_q  <= 1'b0;
        end else begin
            state    <= state_next;
            byte_cnt <= byte_cnt_next;
            busy_q   <= (state_next != ST_IDLE);
            error_q  <= advance && short_frame;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            ip_length_q <= ip_length;
        end
    end

    assign busy = busy_q;
    assign error_payload_early_termination = error_q;

endmodule

`default_nettype wire

// File: verilog/ip_tx_top.sv
/*
 * IPv4 transmit framer, 64-bit datapath
 * takes a parallel header and a payload stream, emits the Ethernet
 * header on its own channel and the IPv4 header plus payload as a stream
 */

`timescale 1ns/1ps
`default_nettype none

`include "ip_tx_defines.svh"

module ip_tx_top (
    input  logic                       clk,
    input  logic                       rst,
    input  ip_hdr_pkg::ip_tx_hdr_t     s_hdr,
    input  logic                       s_hdr_valid,
    output logic                       s_hdr_ready,
    input  axis_beat_pkg::axis_beat_t  s_pay,
    input  logic                       s_pay_valid,
    output logic                       s_pay_ready,
    output ip_hdr_pkg::eth_hdr_t       m_eth,
    output logic                       m_eth_valid,
    input  logic                       m_eth_ready,
    output axis_beat_pkg::axis_beat_t  m_pay,
    output logic                       m_pay_valid,
    input  logic                       m_pay_ready,
    output logic                       busy,
    output logic                       error_payload_early_termination
);

    logic                      capture;
    logic                      word_sel;
    logic [`IP_TX_DATA_W-1:0]  hdr_word;
    logic [31:0]               dest_ip;
    logic                      eth_buf_valid;
    logic                      eth_buf_ready;
    axis_beat_pkg::axis_beat_t realign_beat;
    logic                      realign_valid;
    logic                      advance;
    axis_beat_pkg::axis_beat_t pay_buf_beat;
    logic                      pay_buf_valid;
    logic                      pay_buf_ready;

    ip_tx_ctrl u_ctrl (
        .clk                             (clk),
        .rst                             (rst),
        .hdr_valid                       (s_hdr_valid),
        .hdr_ready                       (s_hdr_ready),
        .capture                         (capture),
        .word_sel                        (word_sel),
        .ip_length                       (s_hdr.ip.length),
        .eth_buf_ready                   (eth_buf_ready),
        .eth_buf_valid                   (eth_buf_valid),
        .realign_beat                    (realign_beat),
        .realign_valid                   (realign_valid),
        .advance                         (advance),
        .hdr_word                        (hdr_word),
        .pay_buf_ready                   (pay_buf_ready),
        .pay_buf_valid                   (pay_buf_valid),
        .pay_buf_beat                    (pay_buf_beat),
        .busy                            (busy),
        .error_payload_early_termination (error_payload_early_termination)
    );

    ip_hdr_builder u_hdr (
        .clk      (clk),
        .capture  (capture),
        .hdr      (s_hdr.ip),
        .word_sel (word_sel),
        .hdr_word (hdr_word),
        .dest_ip  (dest_ip)
    );

    payload_realign u_realign (
        .clk          (clk),
        .rst          (rst),
        .preload      (capture),
        .preload_word (dest_ip),
        .in_beat      (s_pay),
        .in_valid     (s_pay_valid),
        .in_ready     (s_pay_ready),
        .advance      (advance),
        .out_beat     (realign_beat),
        .out_valid    (realign_valid)
    );

    // Ethernet header is pushed on the same edge as the header transfer
    skid_reg #(.T(ip_hdr_pkg::eth_hdr_t)) u_eth_buf (
        .clk       (clk),
        .rst       (rst),
        .in_data   (s_hdr.eth),
        .in_valid  (eth_buf_valid),
        .in_ready  (eth_buf_ready),
        .out_data  (m_eth),
        .out_valid (m_eth_valid),
        .out_ready (m_eth_ready)
    );

    skid_reg #(.T(axis_beat_pkg::axis_beat_t)) u_pay_buf (
        .clk       (clk),
        .rst       (rst),
        .in_data   (pay_buf_beat),
        .in_valid  (pay_buf_valid),
        .in_ready  (pay_buf_ready),
        .out_data  (m_pay),
        .out_valid (m_pay_valid),
        .out_ready (m_pay_ready)
    );

endmodule

`default_nettype wire

// File: verification/ip_tx_sva.sv
/*
 * Output handshake assertions for the IPv4 transmit framer
 * stalled beats stay put on both output channels, and no output
 * valid is high while the framer is held in reset
 */

`timescale 1ns/1ps
`default_nettype none

module ip_tx_sva (
    input logic                      clk,
    input logic                      rst,
    input ip_hdr_pkg::eth_hdr_t      m_eth,
    input logic                      m_eth_valid,
    input logic                      m_eth_ready,
    input axis_beat_pkg::axis_beat_t m_pay,
    input logic                      m_pay_valid,
    input logic                      m_pay_ready
);

    eth_hold: assert property (@(posedge clk) disable iff (rst)
        m_eth_valid && !m_eth_ready |=> m_eth_valid && $stable(m_eth))
        else $error("m_eth dropped or changed while stalled");

    pay_hold: assert property (@(posedge clk) disable iff (rst)
        m_pay_valid && !m_pay_ready |=> m_pay_valid && $stable(m_pay))
        else $error("m_pay dropped or changed while stalled");

    // registered outputs are cleared by the reset edge
    reset_quiet: assert property (@(posedge clk)
        rst |=> !m_eth_valid && !m_pay_valid)
        else $error("output valid high during reset");

endmodule

bind ip_tx_top ip_tx_sva u_sva (
    .clk         (clk),
    .rst         (rst),
    .m_eth       (m_eth),
    .m_eth_valid (m_eth_valid),
    .m_eth_ready (m_eth_ready),
    .m_pay       (m_pay),
    .m_pay_valid (m_pay_valid),
    .m_pay_ready (m_pay_ready)
);

`default_nettype wire

// File: verification/tb_ip_tx.sv
/*
 * Directed testbench for the IPv4 transmit framer
 * drives one frame per call with random field values, collects both
 * output channels and compares them with a byte-level reference
 */

`timescale 1ns/1ps
`default_nettype none

`include "ip_tx_defines.svh"

module tb_ip_tx;

    localparam int PERIOD         = 100;
    localparam int TIMEOUT_CYCLES = 2000;

    typedef logic [7:0] byte_q_t[$];

    logic                      clk;
    logic                      rst;
    ip_hdr_pkg::ip_tx_hdr_t    s_hdr;
    logic                      s_hdr_valid;
    logic                      s_hdr_ready;
    axis_beat_pkg::axis_beat_t s_pay;
    logic                      s_pay_valid;
    logic                      s_pay_ready;
    ip_hdr_pkg::eth_hdr_t      m_eth;
    logic                      m_eth_valid;
    logic                      m_eth_ready;
    axis_beat_pkg::axis_beat_t m_pay;
    logic                      m_pay_valid;
    logic                      m_pay_ready;
    logic                      busy;
    logic                      error_payload_early_termination;

    integer                    seed;
    // stall pattern has its own random sequence
    integer                    stall_seed;
    int                        mismatch_count;
    int                        other_errors;
    int                        pulse_count;
    logic                      stall_en;
    ip_hdr_pkg::eth_hdr_t      eth_q[$];
    axis_beat_pkg::axis_beat_t pay_q[$];
    byte_q_t                   exp_bytes;

    ip_tx_top u_dut (
        .clk                             (clk),
        .rst                             (rst),
        .s_hdr                           (s_hdr),
        .s_hdr_valid                     (s_hdr_valid),
        .s_hdr_ready                     (s_hdr_ready),
        .s_pay                           (s_pay),
        .s_pay_valid                     (s_pay_valid),
        .s_pay_ready                     (s_pay_ready),
        .m_eth                           (m_eth),
        .m_eth_valid                     (m_eth_valid),
        .m_eth_ready                     (m_eth_ready),
        .m_pay                           (m_pay),
        .m_pay_valid                     (m_pay_valid),
        .m_pay_ready                     (m_pay_ready),
        .busy                            (busy),
        .error_payload_early_termination (error_payload_early_termination)
    );

    always #(PERIOD / 2) clk = ~clk;

    // random back-pressure on both outputs
    always @(posedge clk) begin
        if (stall_en) begin
            m_eth_ready <= ($random(stall_seed) & 3) != 0;
            m_pay_ready <= ($random(stall_seed) & 3) != 0;
        end else begin
            m_eth_ready <= 1'b1;
            m_pay_ready <= 1'b1;
        end
    end

    // output monitor
    always @(posedge clk) begin
        if (!rst) begin
            if (m_eth_valid && m_eth_ready) begin
                eth_q.push_back(m_eth);
            end
            if (m_pay_valid && m_pay_ready) begin
                pay_q.push_back(m_pay);
            end
            if (error_payload_early_termination) begin
                pulse_count++;
            end
        end
    end

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    // folded one's-complement sum of the first n bytes as big-endian pairs
    function automatic logic [15:0] ones_sum(input byte_q_t b, input int n);
        logic [31:0] s;
        s = '0;
        for (int i = 0; i + 1 < n; i += 2) begin
            s = s + {b[i], b[i+1]};
        end
        while (s[31:16] != 0) begin
            s = s[15:0] + s[31:16];
        end
        return s[15:0];
    endfunction

    // reference IPv4 header in wire order
    task automatic push_ref_header(input ip_hdr_pkg::ipv4_fields_t f);
        logic [15:0] csum;
        exp_bytes.push_back(8'h45);
        exp_bytes.push_back({f.dscp, f.ecn});
        exp_bytes.push_back(f.length[15:8]);
        exp_bytes.push_back(f.length[7:0]);
        exp_bytes.push_back(f.identification[15:8]);
        exp_bytes.push_back(f.identification[7:0]);
        exp_bytes.push_back({f.flags, f.fragment_offset[12:8]});
        exp_bytes.push_back(f.fragment_offset[7:0]);
        exp_bytes.push_back(f.ttl);
        exp_bytes.push_back(f.protocol);
        exp_bytes.push_back(8'h00);
        exp_bytes.push_back(8'h00);
        for (int i = 3; i >= 0; i--) begin
            exp_bytes.push_back(f.source_ip[8*i +: 8]);
        end
        for (int i = 3; i >= 0; i--) begin
            exp_bytes.push_back(f.dest_ip[8*i +: 8]);
        end
        csum = ~ones_sum(exp_bytes, `IP_TX_HDR_BYTES);
        exp_bytes[10] = csum[15:8];
        exp_bytes[11] = csum[7:0];
    endtask

    task automatic send_header(input ip_hdr_pkg::ip_tx_hdr_t h);
        logic done;
        int   cnt;
        s_hdr       <= h;
        s_hdr_valid <= 1'b1;
        done = 1'b0;
        cnt  = 0;
        while (!done && cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cnt++;
            done = s_hdr_ready;
        end
        assert (done) else begin
            other_errors++;
            $display("timeout waiting for the header to be accepted");
        end
        s_hdr_valid <= 1'b0;
    endtask

    // lane 0 goes first and the last beat keeps only the used lanes
    task automatic send_payload(input byte_q_t b);
        axis_beat_pkg::axis_beat_t beat;
        int   idx;
        int   cnt;
        logic done;
        idx = 0;
        while (idx < b.size()) begin
            beat = '0;
            for (int i = 0; i < `IP_TX_KEEP_W; i++) begin
                if (idx < b.size()) begin
                    beat.data[8*i +: 8] = b[idx];
                    beat.keep[i]        = 1'b1;
                    idx++;
                end
            end
            beat.last = (idx == b.size());
            s_pay       <= beat;
            s_pay_valid <= 1'b1;
            done = 1'b0;
            cnt  = 0;
            while (!done && cnt < TIMEOUT_CYCLES) begin
                @(posedge clk);
                cnt++;
                done = s_pay_ready;
            end
            assert (done) else begin
                other_errors++;
                $display("timeout waiting for a payload beat to be accepted");
            end
        end
        s_pay_valid <= 1'b0;
    endtask

    task automatic wait_frame_end();
        logic done;
        int   cnt;
        done = 1'b0;
        cnt  = 0;
        while (!done && cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cnt++;
            done = eth_q.size() > 0 && pay_q.size() > 0 && pay_q[$].last;
        end
        assert (done) else begin
            other_errors++;
            $display("timeout waiting for the end of the output frame");
        end
    endtask

    task automatic wait_idle();
        logic done;
        int   cnt;
        done = 1'b0;
        cnt  = 0;
        while (!done && cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cnt++;
            done = !busy;
        end
        assert (done) else begin
            other_errors++;
            $display("timeout waiting for busy to return low");
        end
        // lets a late status pulse reach the monitor
        @(posedge clk);
        assert (!m_eth_valid && !m_pay_valid) else begin
            other_errors++;
            $display("an output valid is still high after the frame ended");
        end
    endtask

    task automatic check_frame(input ip_hdr_pkg::ip_tx_hdr_t h, input int n_bytes,
                               input logic short_frame);
        byte_q_t got;
        assert (eth_q.size() == 1) else begin
            mismatch_count++;
            $display("mismatch m_eth beat count: got %h, expected %h", eth_q.size(), 1);
        end
        if (eth_q.size() > 0) begin
            assert (eth_q[0] == h.eth) else begin
                mismatch_count++;
                $display("mismatch m_eth: got %h, expected %h", eth_q[0], h.eth);
            end
        end
        for (int k = 0; k < pay_q.size(); k++) begin
            assert (pay_q[k].last == (k == pay_q.size() - 1)) else begin
                mismatch_count++;
                $display("mismatch m_pay.last on beat %0d: got %h, expected %h",
                         k, pay_q[k].last, k == pay_q.size() - 1);
            end
            for (int i = 0; i < `IP_TX_KEEP_W; i++) begin
                if (pay_q[k].keep[i]) begin
                    got.push_back(pay_q[k].data[8*i +: 8]);
                end
            end
        end
        assert (got.size() == `IP_TX_HDR_BYTES + n_bytes) else begin
            mismatch_count++;
            $display("mismatch m_pay kept bytes: got %h, expected %h",
                     got.size(), `IP_TX_HDR_BYTES + n_bytes);
        end
        for (int k = 0; k < got.size() && k < exp_bytes.size(); k++) begin
            assert (got[k] == exp_bytes[k]) else begin
                mismatch_count++;
                $display("mismatch m_pay byte %0d: got %h, expected %h", k, got[k], exp_bytes[k]);
            end
        end
        if (got.size() >= `IP_TX_HDR_BYTES) begin
            assert (ones_sum(got, `IP_TX_HDR_BYTES) == 16'hffff) else begin
                mismatch_count++;
                $display("mismatch header checksum sum: got %h, expected %h",
                         ones_sum(got, `IP_TX_HDR_BYTES), 16'hffff);
            end
        end
        if (pay_q.size() > 0) begin
            assert (pay_q[$].user == short_frame) else begin
                mismatch_count++;
                $display("mismatch m_pay.user: got %h, expected %h", pay_q[$].user, short_frame);
            end
        end
        assert (pulse_count == (short_frame ? 1 : 0)) else begin
            mismatch_count++;
            $display("mismatch error_payload_early_termination pulses: got %h, expected %h",
                     pulse_count, short_frame);
        end
    endtask

    // one frame where ip_length overstates the payload by extra bytes
    task automatic run_frame(input int n_bytes, input int extra, input logic stall);
        ip_hdr_pkg::ip_tx_hdr_t h;
        byte_q_t                pay_bytes;
        logic [31:0]            r;
        for (int i = 0; i < 8; i++) begin
            h[32*i +: 32] = rand32();
        end
        h.eth.eth_type = 16'h0800;
        h.ip.length    = 16'(`IP_TX_HDR_BYTES + n_bytes + extra);
        for (int i = 0; i < n_bytes; i++) begin
            r = rand32();
            pay_bytes.push_back(r[7:0]);
        end
        exp_bytes.delete();
        push_ref_header(h.ip);
        foreach (pay_bytes[i]) begin
            exp_bytes.push_back(pay_bytes[i]);
        end
        eth_q.delete();
        pay_q.delete();
        pulse_count = 0;
        stall_en <= stall;
        fork
            send_header(h);
            send_payload(pay_bytes);
            wait_frame_end();
        join
        wait_idle();
        check_frame(h, n_bytes, extra > 0);
    endtask

    task automatic idle_after_reset();
        @(posedge clk);
        assert (!busy) else begin
            mismatch_count++;
            $display("mismatch busy: got %h, expected %h", busy, 1'b0);
        end
        assert (!m_eth_valid && !m_pay_valid) else begin
            other_errors++;
            $display("an output valid is high right after reset");
        end
        assert (s_hdr_ready) else begin
            mismatch_count++;
            $display("mismatch s_hdr_ready: got %h, expected %h", s_hdr_ready, 1'b1);
        end
    endtask

    task automatic sweep_payload_sizes();
        for (int n = 1; n <= 17; n++) begin
            run_frame(n, 0, 1'b0);
        end
    endtask

    task automatic short_frame_errors();
        int          sizes[8];
        logic [31:0] r;
        sizes = '{1, 3, 4, 5, 8, 12, 16, 17};
        foreach (sizes[i]) begin
            r = rand32();
            run_frame(sizes[i], 1 + int'(r[2:0]), 1'b0);
        end
    endtask

    task automatic stalled_frames();
        logic [31:0] r;
        for (int f = 0; f < 12; f++) begin
            r = rand32();
            run_frame(1 + int'(r[15:0] % 17), r[16] ? 1 + int'(r[19:17]) : 0, 1'b1);
        end
    endtask

    initial begin
        seed           = 32'h85cd_a1a1;
        stall_seed     = seed;
        mismatch_count = 0;
        other_errors   = 0;
        pulse_count    = 0;
        clk            = 1'b0;
        rst            = 1'b1;
        s_hdr          = '0;
        s_hdr_valid    = 1'b0;
        s_pay          = '0;
        s_pay_valid    = 1'b0;
        m_eth_ready    = 1'b1;
        m_pay_ready    = 1'b1;
        stall_en       = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        idle_after_reset();
        sweep_payload_sizes();
        short_frame_errors();
        stalled_frames();
        $display("error count: %0d mismatches, %0d other failures", mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+verilog
verilog/ip_hdr_pkg.sv
verilog/axis_beat_pkg.sv
verilog/skid_reg.sv
verilog/ip_hdr_builder.sv
verilog/payload_realign.sv
verilog/ip_tx_ctrl.sv
verilog/ip_tx_top.sv
verification/ip_tx_sva.sv
verification/tb_ip_tx.sv

// File: Bender.yml
package:
  name: ip_tx

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/ip_hdr_pkg.sv
      - verilog/axis_beat_pkg.sv
      - verilog/skid_reg.sv
      - verilog/ip_hdr_builder.sv
      - verilog/payload_realign.sv
      - verilog/ip_tx_ctrl.sv
      - verilog/ip_tx_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - verification/ip_tx_sva.sv
      - verification/tb_ip_tx.sv
